//--- design/isa_pkg.sv
package isa_pkg;

    localparam int instr_width = 32;

    // Values not listed here decode as plain instructions
    typedef enum logic [5:0] {
        op_jmp  = 6'b111011,
        op_call = 6'b111100,
        op_csw  = 6'b111101,
        op_end  = 6'b111110
    } opcode_t;

    ////////////////////////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////////////////////////

    // Same word read as scalar or vector operands
    typedef union packed {
        struct packed {
            opcode_t     opcode;
            logic [4:0]  rs1;
            logic [4:0]  rs2;
            logic [15:0] imm16;
        } s;
        struct packed {
            opcode_t     opcode;
            logic        spare1;
            logic [3:0]  vs1;
            logic        spare2;
            logic [3:0]  vs2;
            logic [15:0] imm16;
        } v;
    } instr_t;

endpackage

//--- design/regs_pkg.sv
package regs_pkg;

    localparam int scalar_width = 32;
    localparam int lane_width = 32;

    localparam int scalar_addr_width = 5;
    localparam int vector_addr_width = 4;

    localparam int scalar_count = 2 ** scalar_addr_width;
    localparam int vector_count = 2 ** vector_addr_width;

    // Reads as PC+4 for instructions
    localparam int link_index = 31;

endpackage

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import isa_pkg::*, regs_pkg::*;
#(
    parameter int unsigned reset_pc = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         kernel_mode,
    input  logic [instr_width-1:0]       imem_data,
    input  logic [scalar_addr_width-1:0] host_scalar_addr1,
    input  logic [scalar_addr_width-1:0] host_scalar_addr2,
    input  logic [vector_addr_width-1:0] host_vector_addr1,
    input  logic [vector_addr_width-1:0] host_vector_addr2,
    output logic [scalar_width-1:0]      imem_addr,
    output logic [scalar_width-1:0]      pc,
    output logic                         fetch_valid,
    output logic                         end_program,
    output logic [scalar_addr_width-1:0] rs1,
    output logic [scalar_addr_width-1:0] rs2,
    output logic [vector_addr_width-1:0] vs1,
    output logic [vector_addr_width-1:0] vs2
);

    instr_t                  word;
    logic                    jump;
    logic                    end_hit;
    logic [scalar_width-1:0] next_pc;

    assign word = imem_data;

    ////////////////////////////////////////////////////////////
    // Next address
    ////////////////////////////////////////////////////////////

    assign jump = word.s.opcode == op_jmp || word.s.opcode == op_call;
    assign end_hit = fetch_valid && !kernel_mode && word.s.opcode == op_end;

    always_comb begin
        if (!fetch_valid || kernel_mode || end_program) begin
            next_pc = pc;
        end else if (jump) begin
            next_pc = scalar_width'(word.s.imm16);
        end else begin
            next_pc = pc + scalar_width'(4);
        end
    end

    // Memory is read with the next address so data lands with pc
    assign imem_addr = next_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= scalar_width'(reset_pc);
            fetch_valid <= 1'b0;
            end_program <= 1'b0;
        end else begin
            pc <= next_pc;
            fetch_valid <= !end_program && !end_hit;
            if (end_hit) begin
                end_program <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Register read addresses
    ////////////////////////////////////////////////////////////

    // Early bypass so the synchronous reads line up with decode
    assign rs1 = kernel_mode ? host_scalar_addr1 : word.s.rs1;
    assign rs2 = kernel_mode ? host_scalar_addr2 : word.s.rs2;
    assign vs1 = kernel_mode ? host_vector_addr1 : word.v.vs1;
    assign vs2 = kernel_mode ? host_vector_addr2 : word.v.vs2;

    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    );

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file
    import regs_pkg::*;
#(
    parameter int lanes = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [scalar_addr_width-1:0]  rs1,
    input  logic [scalar_addr_width-1:0]  rs2,
    input  logic [vector_addr_width-1:0]  vs1,
    input  logic [vector_addr_width-1:0]  vs2,
    input  logic                          scalar_wen,
    input  logic [scalar_addr_width-1:0]  scalar_wb_address,
    input  logic [scalar_width-1:0]       scalar_wb_data,
    input  logic                          vector_wen,
    input  logic [vector_addr_width-1:0]  vector_wb_address,
    input  logic [lanes*lane_width-1:0]   vector_wb_data,
    output logic [scalar_width-1:0]       scalar_read1,
    output logic [scalar_width-1:0]       scalar_read2,
    output logic [lanes*lane_width-1:0]   vector_read1,
    output logic [lanes*lane_width-1:0]   vector_read2
);

    localparam int vector_width = lanes * lane_width;

    logic [scalar_width-1:0] scalar_bank [scalar_count];
    logic [vector_width-1:0] vector_bank [vector_count];

    ////////////////////////////////////////////////////////////
    // Host write ports
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < scalar_count; i++) begin
                scalar_bank[i] <= '0;
            end
            for (int j = 0; j < vector_count; j++) begin
                vector_bank[j] <= '0;
            end
        end else begin
            if (scalar_wen) begin
                scalar_bank[scalar_wb_address] <= scalar_wb_data;
            end
            if (vector_wen) begin
                vector_bank[vector_wb_address] <= vector_wb_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered read ports
    ////////////////////////////////////////////////////////////

    // Old contents win over a write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scalar_read1 <= '0;
            scalar_read2 <= '0;
            vector_read1 <= '0;
            vector_read2 <= '0;
        end else begin
            scalar_read1 <= scalar_bank[rs1];
            scalar_read2 <= scalar_bank[rs2];
            vector_read1 <= vector_bank[vs1];
            vector_read2 <= vector_bank[vs2];
        end
    end

    scalar_waddr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        scalar_wen |-> !$isunknown(scalar_wb_address)
    );

    vector_waddr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        vector_wen |-> !$isunknown(vector_wb_address)
    );

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*, regs_pkg::*;
#(
    parameter int lanes = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [scalar_width-1:0]     pc,
    input  logic                        fetch_valid,
    input  logic                        kernel_mode,
    input  logic [instr_width-1:0]      imem_data,
    input  logic [scalar_width-1:0]     scalar_read1,
    input  logic [scalar_width-1:0]     scalar_read2,
    input  logic [lanes*lane_width-1:0] vector_read1,
    input  logic [lanes*lane_width-1:0] vector_read2,
    output logic                        de_valid,
    output logic [scalar_width-1:0]     de_pc,
    output opcode_t                     de_opcode,
    output logic [scalar_width-1:0]     de_scalar1,
    output logic [scalar_width-1:0]     de_scalar2,
    output logic [lanes*lane_width-1:0] de_vector1,
    output logic [lanes*lane_width-1:0] de_vector2,
    output logic [scalar_width-1:0]     de_branch_target,
    output logic                        context_switch
);

    instr_t                  fetch_word;
    instr_t                  de_instr;
    logic [scalar_width-1:0] de_pc_plus4;
    logic                    take;

    assign fetch_word = imem_data;
    assign take = fetch_valid && !kernel_mode;

    ////////////////////////////////////////////////////////////
    // Fetch to decode register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_valid <= 1'b0;
            context_switch <= 1'b0;
        end else begin
            de_valid <= take;
            context_switch <= take && fetch_word.s.opcode == op_csw;
        end
    end

    always_ff @(posedge clk) begin
        de_instr <= fetch_word;
        de_pc <= pc;
        de_pc_plus4 <= pc + scalar_width'(4);
    end

    ////////////////////////////////////////////////////////////
    // Operands
    ////////////////////////////////////////////////////////////

    assign de_opcode = de_instr.s.opcode;

    // Link register reads as return address
    assign de_scalar1 = (de_instr.s.rs1 == scalar_addr_width'(link_index)) ?
                        de_pc_plus4 : scalar_read1;
    assign de_scalar2 = (de_instr.s.rs2 == scalar_addr_width'(link_index)) ?
                        de_pc_plus4 : scalar_read2;

    assign de_vector1 = vector_read1;
    assign de_vector2 = vector_read2;

    assign de_branch_target = de_pc_plus4 +
        {{(scalar_width-16){de_instr.s.imm16[15]}}, de_instr.s.imm16};

    csw_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) context_switch |=> !context_switch
    );

endmodule

//--- design/rt_core.sv
`timescale 1ns/1ps

module rt_core
    import isa_pkg::*, regs_pkg::*;
#(
    parameter int          lanes    = 4,
    parameter int unsigned reset_pc = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         kernel_mode,
    input  logic [scalar_addr_width-1:0] host_scalar_addr1,
    input  logic [scalar_addr_width-1:0] host_scalar_addr2,
    input  logic [vector_addr_width-1:0] host_vector_addr1,
    input  logic [vector_addr_width-1:0] host_vector_addr2,
    input  logic                         scalar_wen,
    input  logic [scalar_addr_width-1:0] scalar_wb_address,
    input  logic [scalar_width-1:0]      scalar_wb_data,
    input  logic                         vector_wen,
    input  logic [vector_addr_width-1:0] vector_wb_address,
    input  logic [lanes*lane_width-1:0]  vector_wb_data,
    output logic [scalar_width-1:0]      imem_addr,
    input  logic [instr_width-1:0]       imem_data,
    output logic [scalar_width-1:0]      scalar_read1,
    output logic [scalar_width-1:0]      scalar_read2,
    output logic [lanes*lane_width-1:0]  vector_read1,
    output logic [lanes*lane_width-1:0]  vector_read2,
    output logic                         de_valid,
    output logic [scalar_width-1:0]      de_pc,
    output opcode_t                      de_opcode,
    output logic [scalar_width-1:0]      de_scalar1,
    output logic [scalar_width-1:0]      de_scalar2,
    output logic [lanes*lane_width-1:0]  de_vector1,
    output logic [lanes*lane_width-1:0]  de_vector2,
    output logic [scalar_width-1:0]      de_branch_target,
    output logic                         end_program,
    output logic                         context_switch
);

    logic [scalar_width-1:0]      pc;
    logic                         fetch_valid;
    logic [scalar_addr_width-1:0] rs1;
    logic [scalar_addr_width-1:0] rs2;
    logic [vector_addr_width-1:0] vs1;
    logic [vector_addr_width-1:0] vs2;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk              (clk),
        .rst_n            (rst_n),
        .kernel_mode      (kernel_mode),
        .imem_data        (imem_data),
        .host_scalar_addr1(host_scalar_addr1),
        .host_scalar_addr2(host_scalar_addr2),
        .host_vector_addr1(host_vector_addr1),
        .host_vector_addr2(host_vector_addr2),
        .imem_addr        (imem_addr),
        .pc               (pc),
        .fetch_valid      (fetch_valid),
        .end_program      (end_program),
        .rs1              (rs1),
        .rs2              (rs2),
        .vs1              (vs1),
        .vs2              (vs2)
    );

    // Read data serves host reads and decode operands alike
    register_file #(
        .lanes(lanes)
    ) u_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .rs1              (rs1),
        .rs2              (rs2),
        .vs1              (vs1),
        .vs2              (vs2),
        .scalar_wen       (scalar_wen),
        .scalar_wb_address(scalar_wb_address),
        .scalar_wb_data   (scalar_wb_data),
        .vector_wen       (vector_wen),
        .vector_wb_address(vector_wb_address),
        .vector_wb_data   (vector_wb_data),
        .scalar_read1     (scalar_read1),
        .scalar_read2     (scalar_read2),
        .vector_read1     (vector_read1),
        .vector_read2     (vector_read2)
    );

    decode_stage #(
        .lanes(lanes)
    ) u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc              (pc),
        .fetch_valid     (fetch_valid),
        .kernel_mode     (kernel_mode),
        .imem_data       (imem_data),
        .scalar_read1    (scalar_read1),
        .scalar_read2    (scalar_read2),
        .vector_read1    (vector_read1),
        .vector_read2    (vector_read2),
        .de_valid        (de_valid),
        .de_pc           (de_pc),
        .de_opcode       (de_opcode),
        .de_scalar1      (de_scalar1),
        .de_scalar2      (de_scalar2),
        .de_vector1      (de_vector1),
        .de_vector2      (de_vector2),
        .de_branch_target(de_branch_target),
        .context_switch  (context_switch)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

endmodule

//--- testbench/rt_core_tb.sv
`timescale 1ns/1ps

module rt_core_tb
    import regs_pkg::*;
();

    localparam int lanes = 4;
    localparam int vector_width = lanes * lane_width;
    localparam int clk_period = 4;
    localparam logic [1:0] chk_dec = 2'b01;
    localparam logic [1:0] chk_host = 2'b10;
    localparam logic [5:0] opc_plain = 6'b000001;
    localparam logic [5:0] opc_jmp = 6'b111011;
    localparam logic [5:0] opc_call = 6'b111100;
    localparam logic [5:0] opc_csw = 6'b111101;
    localparam logic [5:0] opc_end = 6'b111110;

    // One cycle of inputs and the outputs expected in it
    typedef struct packed {
        logic        km;
        logic        swen;
        logic        vwen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [4:0]  ha1;
        logic [4:0]  ha2;
        logic [1:0]  mask;
        logic        valid;
        logic [31:0] pc;
        logic        end_p;
        logic        csw;
    } row_t;

    logic clk, rst_n, kernel_mode, scalar_wen, vector_wen;
    logic de_valid, end_program, context_switch;
    logic [scalar_addr_width-1:0] host_scalar_addr1, host_scalar_addr2, scalar_wb_address;
    logic [vector_addr_width-1:0] host_vector_addr1, host_vector_addr2, vector_wb_address;
    logic [scalar_width-1:0] scalar_wb_data, imem_addr, imem_data, scalar_read1, scalar_read2;
    logic [scalar_width-1:0] de_pc, de_scalar1, de_scalar2, de_branch_target;
    logic [vector_width-1:0] vector_wb_data, vector_read1, vector_read2, de_vector1, de_vector2;
    logic [5:0]              de_opcode;

    logic [31:0]             mem [64];
    logic [scalar_width-1:0] ref_scalar [32];
    logic [vector_width-1:0] ref_vector [16];
    logic [scalar_width-1:0] pend_s1, pend_s2;
    logic [vector_width-1:0] pend_v1, pend_v2;
    row_t                    rows [$];
    logic                    rows_loaded = 1'b0;
    integer                  seed;

    tb_clock #(.period_ns(clk_period)) u_clock (.clk(clk));

    rt_core #(.lanes(lanes), .reset_pc(0)) dut (.*);

    // Synchronous instruction memory
    always @(posedge clk) begin
        imem_data <= mem[imem_addr[7:2]];
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] encode(input logic [5:0] op, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [15:0] imm);
        return {op, rs1, rs2, imm};
    endfunction

    // Lanes differ so a swapped lane shows up
    function automatic logic [vector_width-1:0] lane_pattern(input logic [31:0] d);
        logic [vector_width-1:0] v;
        for (int l = 0; l < lanes; l++) begin
            v[l*lane_width +: lane_width] = d ^ (32'h1010_1010 * l);
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [vector_width-1:0] actual,
                           input logic [vector_width-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < 64; a++) begin
            mem[a] = {6'b000010, 10'(a), 16'(a * 16'h0101 ^ 16'h5a3c)};
        end
        mem[0] = encode(opc_plain, 5'd1, 5'd31, 16'hfff0);
        mem[1] = {opc_plain, 26'($random(seed))};
        mem[2] = encode(opc_plain, 5'd31, 5'd2, 16'h0010);
        mem[3] = encode(opc_jmp, 5'd0, 5'd0, 16'h0020);
        mem[8] = encode(opc_plain, 5'd3, 5'd4, 16'h7fff);
        mem[9] = encode(opc_call, 5'd0, 5'd0, 16'h0030);
        mem[12] = encode(opc_csw, 5'd5, 5'd6, 16'h0000);
        mem[13] = {opc_plain, 26'($random(seed))};
        mem[14] = encode(opc_plain, 5'd2, 5'd1, 16'h8004);
        mem[15] = encode(opc_end, 5'd0, 5'd0, 16'h0000);
    endtask

    task automatic add_row(input logic km, swen, vwen, input logic [4:0] waddr,
                           input logic [31:0] wdata, input logic [4:0] ha1, ha2,
                           input logic [1:0] mask, input logic valid,
                           input logic [31:0] pc, input logic end_p, csw);
        rows.push_back({km, swen, vwen, waddr, wdata, ha1, ha2, mask, valid, pc, end_p, csw});
    endtask

    task automatic apply_row(input row_t r);
        kernel_mode <= r.km;
        scalar_wen <= r.swen;
        scalar_wb_address <= r.waddr;
        scalar_wb_data <= r.wdata;
        vector_wen <= r.vwen;
        vector_wb_address <= r.waddr[3:0];
        vector_wb_data <= lane_pattern(r.wdata);
        host_scalar_addr1 <= r.ha1;
        host_scalar_addr2 <= r.ha2;
        host_vector_addr1 <= r.ha1[3:0];
        host_vector_addr2 <= r.ha2[3:0];
    endtask

    // Decode outputs rebuilt from the program listing
    task automatic check_decode(input logic [31:0] pc);
        logic [31:0] w;
        logic [31:0] link;
        w = mem[pc[7:2]];
        link = pc + 32'd4;
        compare("de_pc", de_pc, pc);
        compare("de_opcode", de_opcode, w[31:26]);
        compare("de_scalar1", de_scalar1,
                w[25:21] == link_index ? link : ref_scalar[w[25:21]]);
        compare("de_scalar2", de_scalar2,
                w[20:16] == link_index ? link : ref_scalar[w[20:16]]);
        compare("de_vector1", de_vector1, ref_vector[w[24:21]]);
        compare("de_vector2", de_vector2, ref_vector[w[19:16]]);
        compare("de_branch_target", de_branch_target, link + {{16{w[15]}}, w[15:0]});
    endtask

    task automatic check_row(input row_t r);
        compare("de_valid", de_valid, r.valid);
        compare("end_program", end_program, r.end_p);
        compare("context_switch", context_switch, r.csw);
        if (r.mask[1]) begin
            compare("scalar_read1", scalar_read1, pend_s1);
            compare("scalar_read2", scalar_read2, pend_s2);
            compare("vector_read1", vector_read1, pend_v1);
            compare("vector_read2", vector_read2, pend_v2);
        end
        if (r.mask[0]) begin
            check_decode(r.pc);
        end
    endtask

    // Reads see the banks before this cycle's write
    task automatic update_model(input row_t r);
        pend_s1 = ref_scalar[r.ha1];
        pend_s2 = ref_scalar[r.ha2];
        pend_v1 = ref_vector[r.ha1[3:0]];
        pend_v2 = ref_vector[r.ha2[3:0]];
        if (r.swen) begin
            ref_scalar[r.waddr] = r.wdata;
        end
        if (r.vwen) begin
            ref_vector[r.waddr[3:0]] = lane_pattern(r.wdata);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        seed = 9856;
        rst_n = 1'b0;
        kernel_mode = 1'b1;
        {scalar_wen, vector_wen} = 2'b00;
        {host_scalar_addr1, host_scalar_addr2, host_vector_addr1, host_vector_addr2} = '0;
        {scalar_wb_address, scalar_wb_data, vector_wb_address, vector_wb_data} = '0;
        imem_data = '0;
        {pend_s1, pend_s2, pend_v1, pend_v2} = '0;
        ref_scalar = '{default: '0};
        ref_vector = '{default: '0};
        load_program();

        // Host writes and reads in kernel mode
        add_row(1, 1, 1, 1, 32'ha5a5_0001, 0, 0, chk_host, 0, 32'h00, 0, 0);
        add_row(1, 1, 1, 2, 32'h0bad_f00d, 1, 2, chk_host, 0, 32'h00, 0, 0);
        add_row(1, 1, 0, 3, 32'h3333_0003, 2, 3, chk_host, 0, 32'h00, 0, 0);
        add_row(1, 1, 1, 4, 32'h4444_0004, 3, 4, chk_host, 0, 32'h00, 0, 0);
        add_row(1, 1, 1, 31, 32'hffee_001f, 4, 31, chk_host, 0, 32'h00, 0, 0);
        add_row(1, 0, 0, 0, 32'h0, 31, 1, chk_host, 0, 32'h00, 0, 0);
        // Program runs through jmp, call and csw
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_host, 0, 32'h00, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h00, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h04, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h08, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h0c, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h20, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h24, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h30, 0, 1);
        // Kernel window in mid-program with fetch resuming at 0x38
        add_row(1, 1, 1, 2, 32'h2222_beef, 1, 2, chk_dec, 1, 32'h34, 0, 0);
        add_row(1, 1, 0, 1, 32'h1111_cafe, 2, 1, chk_host, 0, 32'h00, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_host, 0, 32'h00, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h38, 0, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, chk_dec, 1, 32'h3c, 1, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, 2'b00, 0, 32'h00, 1, 0);
        add_row(1, 0, 0, 0, 32'h0, 0, 0, 2'b00, 0, 32'h00, 1, 0);
        add_row(0, 0, 0, 0, 32'h0, 0, 0, 2'b00, 0, 32'h00, 1, 0);
        rows_loaded = 1'b1;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare("imem_addr", imem_addr, 0);
        compare("de_valid", de_valid, 0);
        compare("end_program", end_program, 0);
        compare("context_switch", context_switch, 0);

        foreach (rows[i]) begin
            @(posedge clk);
            apply_row(rows[i]);
            @(negedge clk);
            check_row(rows[i]);
            update_model(rows[i]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        wait (rows_loaded);
        #((rows.size() + 20) * clk_period);
        $display("Watchdog expired before the stimulus table was finished");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

endmodule

//--- src.f
design/isa_pkg.sv
design/regs_pkg.sv
design/fetch_unit.sv
design/register_file.sv
design/decode_stage.sv
design/rt_core.sv
testbench/tb_clock.sv
testbench/rt_core_tb.sv
